// ==== source/dcmp_params_pkg.sv ====
// Engine and memory dimensions; changing POLY_N or WORD_W also changes the
// read count per command, so keep them as powers of two

`default_nettype none

package dcmp_params_pkg;

    // Memory interfaces
    localparam int API_ADDR_W = 14;
    localparam int API_HALF_W = 32;
    localparam int WORD_W     = 64;
    localparam int MEM_LANE_W = 24;

    // Polynomial arithmetic
    localparam int POLY_N        = 256;
    localparam int Q_VAL         = 3329;
    localparam int Q_W           = 12;
    localparam int COEFF_PER_CLK = 4;
    localparam int WR_PER_POLY   = POLY_N / COEFF_PER_CLK;

    // Unpack buffer and its fill count, sized for 0 to BUF_W bits
    localparam int BUF_W  = 104;
    localparam int FILL_W = $clog2(BUF_W + 1);

    // Command counters; up to 4 polynomials per command
    localparam int RD_CNT_W = 8;
    localparam int WR_CNT_W = 9;

endpackage

`default_nettype wire

// ==== source/dcmp_types_pkg.sv ====
// Mode and memory command encodings; the bit count for mode_d12 is also
// the fallback for any other mode value

`default_nettype none

package dcmp_types_pkg;

    typedef enum logic [1:0] {
        mode_d1  = 2'd0,
        mode_d5  = 2'd1,
        mode_d11 = 2'd2,
        mode_d12 = 2'd3
    } dcmp_mode_t;

    typedef enum logic [1:0] {
        cmd_idle  = 2'd0,
        cmd_read  = 2'd1,
        cmd_write = 2'd2
    } mem_cmd_t;

    // Compressed field width d for each mode
    function automatic logic [3:0] dcmp_bits(input dcmp_mode_t mode);
        logic [3:0] d;
        case (mode)
            mode_d1:  d = 4'd1;
            mode_d5:  d = 4'd5;
            mode_d11: d = 4'd11;
            default:  d = 4'd12;
        endcase
        return d;
    endfunction

endpackage

`default_nettype wire

// ==== source/dcmp_read_ctrl.sv ====
// Issues num_poly*d*4 reads at consecutive word addresses; start_i must not
// arrive while busy, the top masks it

`timescale 1ns/1ps
`default_nettype none

module dcmp_read_ctrl
    import dcmp_params_pkg::*;
    import dcmp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  start_i,
    input  dcmp_mode_t            mode_i,
    input  logic [2:0]            num_poly_i,
    input  logic [API_ADDR_W-1:0] src_base_i,
    input  logic                  hold_i,
    input  logic                  done_i,
    output logic                  busy_o,
    output logic                  rd_en_o,
    output logic [API_ADDR_W-1:0] rd_addr_o
);

    logic                  busy_q;
    logic [API_ADDR_W-1:0] rd_addr_q;
    logic [RD_CNT_W-1:0]   rd_cnt_q;
    logic [RD_CNT_W-1:0]   rd_total;

    // Words per command: polynomials * d * (POLY_N / WORD_W)
    assign rd_total = RD_CNT_W'(num_poly_i) * RD_CNT_W'(dcmp_bits(mode_i))
                    * RD_CNT_W'(POLY_N / WORD_W);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
        end else if (zeroize_i) begin
            busy_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    // Stop once every word has been requested, and back off while the
    // unpacker has no room for another word
    assign rd_en_o = busy_q & (rd_cnt_q != rd_total) & ~hold_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr_q <= '0;
            rd_cnt_q  <= '0;
        end else if (zeroize_i) begin
            rd_addr_q <= '0;
            rd_cnt_q  <= '0;
        end else if (start_i) begin
            rd_addr_q <= src_base_i;
            rd_cnt_q  <= '0;
        end else if (rd_en_o) begin
            rd_addr_q <= rd_addr_q + API_ADDR_W'(1);
            rd_cnt_q  <= rd_cnt_q + RD_CNT_W'(1);
        end
    end

    assign busy_o    = busy_q;
    assign rd_addr_o = rd_addr_q;

endmodule

`default_nettype wire

// ==== source/dcmp_unpack.sv ====
// Bit buffer filled LSB first from 64-bit words, drained 4*d bits per write;
// each lane is round(3329*x / 2^d), zero-padded to the memory lane

`timescale 1ns/1ps
`default_nettype none

module dcmp_unpack
    import dcmp_params_pkg::*;
    import dcmp_types_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    zeroize_i,
    input  dcmp_mode_t                              mode_i,
    input  logic                                    in_valid_i,
    input  logic [1:0][API_HALF_W-1:0]              in_data_i,
    input  logic                                    busy_i,
    output logic                                    hold_o,
    output logic                                    out_valid_o,
    output logic [COEFF_PER_CLK-1:0][MEM_LANE_W-1:0] wr_data_o
);

    logic [BUF_W-1:0]                   bit_buf_q;
    logic [BUF_W-1:0]                   bit_buf_shift;
    logic [BUF_W-1:0]                   bit_buf_d;
    logic [FILL_W-1:0]                  fill_q;
    logic [FILL_W-1:0]                  fill_after;
    logic [FILL_W-1:0]                  fill_d;
    logic [3:0]                         d;
    logic [FILL_W-1:0]                  need;
    logic [COEFF_PER_CLK-1:0][Q_W-1:0]  field;
    // 12x12-bit product fits in a lane width
    logic [COEFF_PER_CLK-1:0][MEM_LANE_W-1:0] prod;
    logic [COEFF_PER_CLK-1:0][MEM_LANE_W-1:0] rounded;

    assign d    = dcmp_bits(mode_i);
    assign need = FILL_W'(COEFF_PER_CLK * d);

    // Stale bits after a zeroize must never reach memory
    assign out_valid_o = busy_i & (fill_q >= need);

    // Drain the bottom first, then append the new word above what is left
    always_comb begin
        bit_buf_shift = out_valid_o ? (bit_buf_q >> need) : bit_buf_q;
        fill_after    = out_valid_o ? (fill_q - need) : fill_q;
        if (in_valid_i) begin
            bit_buf_d = bit_buf_shift | (BUF_W'(in_data_i) << fill_after);
            fill_d    = fill_after + FILL_W'(WORD_W);
        end else begin
            bit_buf_d = bit_buf_shift;
            fill_d    = fill_after;
        end
    end

    // A read issued now lands next cycle, so leave a full word of room
    assign hold_o = fill_d > FILL_W'(BUF_W - WORD_W);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_buf_q <= '0;
            fill_q    <= '0;
        end else if (zeroize_i) begin
            bit_buf_q <= '0;
            fill_q    <= '0;
        end else begin
            bit_buf_q <= bit_buf_d;
            fill_q    <= fill_d;
        end
    end

    // Field extraction, lane i takes bits [i*d +: d]
    always_comb begin
        for (int i = 0; i < COEFF_PER_CLK; i++) begin
            case (mode_i)
                mode_d1:  field[i] = Q_W'(bit_buf_q[i*1 +: 1]);
                mode_d5:  field[i] = Q_W'(bit_buf_q[i*5 +: 5]);
                mode_d11: field[i] = Q_W'(bit_buf_q[i*11 +: 11]);
                default:  field[i] = Q_W'(bit_buf_q[i*12 +: 12]);
            endcase
        end
    end

    // Decompress: (x*q + 2^(d-1)) >> d
    always_comb begin
        for (int i = 0; i < COEFF_PER_CLK; i++) begin
            prod[i]      = MEM_LANE_W'(field[i]) * MEM_LANE_W'(Q_VAL);
            rounded[i]   = (prod[i] + (MEM_LANE_W'(1) << (d - 4'd1))) >> d;
            wr_data_o[i] = MEM_LANE_W'(rounded[i][Q_W-1:0]);
        end
    end

endmodule

`default_nettype wire

// ==== source/dcmp_write_ctrl.sv ====
// Counts num_poly*64 writes from dest_base_i; done_o follows the last write

`timescale 1ns/1ps
`default_nettype none

module dcmp_write_ctrl
    import dcmp_params_pkg::*;
    import dcmp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  start_i,
    input  logic [2:0]            num_poly_i,
    input  logic [API_ADDR_W-1:0] dest_base_i,
    input  logic                  wr_valid_i,
    output mem_cmd_t              wr_cmd_o,
    output logic [API_ADDR_W-1:0] wr_addr_o,
    output logic                  done_o
);

    logic [API_ADDR_W-1:0] wr_addr_q;
    logic [WR_CNT_W-1:0]   wr_cnt_q;
    logic [WR_CNT_W-1:0]   wr_total;
    logic                  last_wr;
    logic                  done_q;

    assign wr_total = WR_CNT_W'(num_poly_i) * WR_CNT_W'(WR_PER_POLY);
    assign last_wr  = wr_valid_i & (wr_cnt_q + WR_CNT_W'(1) == wr_total);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr_q <= '0;
            wr_cnt_q  <= '0;
            done_q    <= 1'b0;
        end else if (zeroize_i) begin
            wr_addr_q <= '0;
            wr_cnt_q  <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= last_wr;
            if (start_i) begin
                wr_addr_q <= dest_base_i;
                wr_cnt_q  <= '0;
            end else if (wr_valid_i) begin
                wr_addr_q <= wr_addr_q + API_ADDR_W'(1);
                wr_cnt_q  <= wr_cnt_q + WR_CNT_W'(1);
            end
        end
    end

    assign wr_cmd_o  = wr_valid_i ? cmd_write : cmd_idle;
    assign wr_addr_o = wr_addr_q;
    assign done_o    = done_q;

endmodule

`default_nettype wire

// ==== source/dcmp_top.sv ====
// Read data must return exactly one cycle after rd_en_o, and the coefficient
// memory must take a write every cycle; mode and num_poly stay stable while busy

`timescale 1ns/1ps
`default_nettype none

module dcmp_top
    import dcmp_params_pkg::*;
    import dcmp_types_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    zeroize_i,
    input  logic                                    start_i,
    input  dcmp_mode_t                              mode_i,
    input  logic [2:0]                              num_poly_i,
    input  logic [API_ADDR_W-1:0]                   src_base_i,
    input  logic [API_ADDR_W-1:0]                   dest_base_i,
    output logic                                    rd_en_o,
    output logic [API_ADDR_W-1:0]                   rd_addr_o,
    input  logic [1:0][API_HALF_W-1:0]              rd_data_i,
    output mem_cmd_t                                wr_cmd_o,
    output logic [API_ADDR_W-1:0]                   wr_addr_o,
    output logic [COEFF_PER_CLK-1:0][MEM_LANE_W-1:0] wr_data_o,
    output logic                                    done_o
);

    logic busy;
    logic start_go;
    logic rd_en;
    logic rd_valid_q;
    logic hold;
    logic out_valid;

    // A start while a command runs is dropped
    assign start_go = start_i & ~busy;

    dcmp_read_ctrl u_read_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .start_i    (start_go),
        .mode_i     (mode_i),
        .num_poly_i (num_poly_i),
        .src_base_i (src_base_i),
        .hold_i     (hold),
        .done_i     (done_o),
        .busy_o     (busy),
        .rd_en_o    (rd_en),
        .rd_addr_o  (rd_addr_o)
    );

    // Read data is valid the cycle after the request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
        end
    end

    dcmp_unpack u_unpack (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .mode_i      (mode_i),
        .in_valid_i  (rd_valid_q),
        .in_data_i   (rd_data_i),
        .busy_i      (busy),
        .hold_o      (hold),
        .out_valid_o (out_valid),
        .wr_data_o   (wr_data_o)
    );

    dcmp_write_ctrl u_write_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_go),
        .num_poly_i  (num_poly_i),
        .dest_base_i (dest_base_i),
        .wr_valid_i  (out_valid),
        .wr_cmd_o    (wr_cmd_o),
        .wr_addr_o   (wr_addr_o),
        .done_o      (done_o)
    );

    assign rd_en_o = rd_en;

endmodule

`default_nettype wire

// ==== dv/dcmp_unpack_chk.sv ====
// Assertions on the unpack buffer and strobes of every bound dcmp_unpack

`timescale 1ns/1ps
`default_nettype none

module dcmp_unpack_chk
    import dcmp_params_pkg::*;
(
    input logic              clk,
    input logic              reset_n,
    input logic [FILL_W-1:0] fill_i,
    input logic              busy_i,
    input logic              out_valid_i,
    input logic              in_valid_i,
    input logic              hold_i
);

    fill_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        fill_i <= FILL_W'(BUF_W))
        else $error("unpack fill count exceeds the buffer width");

    // An idle engine holds no stale bits that a later command could write out
    idle_buffer_empty: assert property (@(posedge clk) disable iff (!reset_n)
        !busy_i |-> (fill_i == '0) && !out_valid_i)
        else $error("unpack buffer holds bits while the engine is not busy");

    // A word lands one cycle after its read, which hold must have allowed
    no_word_under_hold: assert property (@(posedge clk) disable iff (!reset_n)
        in_valid_i |-> !$past(hold_i))
        else $error("unpacker received a word that hold should have blocked");

endmodule

bind dcmp_unpack dcmp_unpack_chk u_unpack_chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .fill_i      (fill_q),
    .busy_i      (busy_i),
    .out_valid_i (out_valid_o),
    .in_valid_i  (in_valid_i),
    .hold_i      (hold_o)
);

`default_nettype wire

// ==== dv/dcmp_monitor.sv ====
// Watches the DUT ports and checks every read, write and done pulse
// against a model of the command; the image must not change while busy

`timescale 1ns/1ps
`default_nettype none

module dcmp_monitor
    import dcmp_params_pkg::*;
    import dcmp_types_pkg::*;
#(
    parameter int IMG_DEPTH = 512
) (
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     zeroize_i,
    input  logic                                     start_i,
    input  dcmp_mode_t                               mode_i,
    input  logic [2:0]                               num_poly_i,
    input  logic [API_ADDR_W-1:0]                    src_base_i,
    input  logic [API_ADDR_W-1:0]                    dest_base_i,
    input  logic                                     rd_en_i,
    input  logic [API_ADDR_W-1:0]                    rd_addr_i,
    input  mem_cmd_t                                 wr_cmd_i,
    input  logic [API_ADDR_W-1:0]                    wr_addr_i,
    input  logic [COEFF_PER_CLK-1:0][MEM_LANE_W-1:0] wr_data_i,
    input  logic                                     done_i,
    input  logic [WORD_W-1:0]                        img_i [IMG_DEPTH],
    output int                                       err_cnt_o,
    output int                                       done_cnt_o
);

    localparam int IDX_W = $clog2(IMG_DEPTH);

    bit                    active;
    bit                    was_active;
    bit                    last_prev;
    dcmp_mode_t            cmd_mode;
    int                    cmd_num;
    int                    cmd_d;
    int                    rd_cnt;
    int                    wr_cnt;
    int                    rd_total;
    int                    wr_total;
    logic [API_ADDR_W-1:0] cmd_src;
    logic [API_ADDR_W-1:0] cmd_dest;
    logic [MEM_LANE_W-1:0] exp_lane;

    function automatic int field_bits(input dcmp_mode_t mode);
        int d;
        case (mode)
            mode_d1:  d = 1;
            mode_d5:  d = 5;
            mode_d11: d = 11;
            default:  d = 12;
        endcase
        return d;
    endfunction

    // Coefficient idx of the stream, packed LSB first from word src upward
    function automatic logic [Q_W-1:0] ref_coeff(input logic [WORD_W-1:0] img [IMG_DEPTH],
                                                 input int src, input dcmp_mode_t mode,
                                                 input int idx);
        int         d;
        int         p;
        int         x;
        logic [IDX_W-1:0] w;
        logic [5:0] b;
        d = field_bits(mode);
        x = 0;
        for (int k = 0; k < d; k++) begin
            p = idx * d + k;
            w = IDX_W'((src + p / 64) % IMG_DEPTH);
            b = 6'(p % 64);
            x = x | (int'(img[w][b]) << k);
        end
        return Q_W'((x * 3329 + (1 << (d - 1))) >> d);
    endfunction

    task automatic report(input string what, input int exp_v, input int act_v);
        $display("[FAIL] cmd %0d %s expected %0h actual %0h", cmd_num, what, exp_v, act_v);
        err_cnt_o++;
    endtask

    initial begin
        err_cnt_o  = 0;
        done_cnt_o = 0;
        cmd_num    = 0;
    end

    always @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            active    = 1'b0;
            last_prev = 1'b0;
        end else begin
            was_active = active;
            if (done_i) begin
                if (!was_active) begin
                    $display("done_o pulsed with no command running (cmd %0d)", cmd_num);
                    err_cnt_o++;
                end else begin
                    if (!last_prev) begin
                        $display("done_o did not follow the last write (cmd %0d)", cmd_num);
                        err_cnt_o++;
                    end
                    if (wr_cnt != wr_total) report("write count", wr_total, wr_cnt);
                    if (rd_cnt != rd_total) report("read count", rd_total, rd_cnt);
                    done_cnt_o++;
                end
                active = 1'b0;
            end
            if (rd_en_i) begin
                if (!was_active || rd_cnt >= rd_total) begin
                    $display("unexpected read at %0h (cmd %0d)", rd_addr_i, cmd_num);
                    err_cnt_o++;
                end else if (rd_addr_i !== cmd_src + API_ADDR_W'(rd_cnt)) begin
                    report("rd_addr", int'(cmd_src + API_ADDR_W'(rd_cnt)), int'(rd_addr_i));
                end
                rd_cnt++;
            end
            last_prev = 1'b0;
            if (wr_cmd_i == cmd_write) begin
                if (!was_active || wr_cnt >= wr_total) begin
                    $display("unexpected write at %0h (cmd %0d)", wr_addr_i, cmd_num);
                    err_cnt_o++;
                end else begin
                    if (wr_addr_i !== cmd_dest + API_ADDR_W'(wr_cnt)) begin
                        report("wr_addr", int'(cmd_dest + API_ADDR_W'(wr_cnt)),
                               int'(wr_addr_i));
                    end
                    for (int i = 0; i < COEFF_PER_CLK; i++) begin
                        exp_lane = MEM_LANE_W'(ref_coeff(img_i, int'(cmd_src), cmd_mode,
                                                         wr_cnt * COEFF_PER_CLK + i));
                        if (wr_data_i[i] !== exp_lane) begin
                            report($sformatf("wr_lane%0d@%0d", i, wr_cnt),
                                   int'(exp_lane), int'(wr_data_i[i]));
                        end
                    end
                end
                wr_cnt++;
                last_prev = was_active && (wr_cnt == wr_total);
            end
            // The DUT drops a start that arrives while busy
            if (start_i && !was_active) begin
                active   = 1'b1;
                cmd_num++;
                cmd_mode = mode_i;
                cmd_d    = field_bits(mode_i);
                cmd_src  = src_base_i;
                cmd_dest = dest_base_i;
                rd_cnt   = 0;
                wr_cnt   = 0;
                rd_total = int'(num_poly_i) * cmd_d * (POLY_N / WORD_W);
                wr_total = int'(num_poly_i) * WR_PER_POLY;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/dcmp_tb.sv ====
// Runs every mode and polynomial count, a start while busy and a zeroize
// abort; the API memory model answers one cycle after each read

`timescale 1ns/1ps
`default_nettype none

module dcmp_tb
    import dcmp_params_pkg::*;
    import dcmp_types_pkg::*;
;

    localparam int IMG_DEPTH = 512;
    localparam int DONE_LIMIT = 2000;

    logic                                     clk;
    logic                                     reset_n;
    logic                                     zeroize;
    logic                                     start;
    dcmp_mode_t                               mode;
    logic [2:0]                               num_poly;
    logic [API_ADDR_W-1:0]                    src_base;
    logic [API_ADDR_W-1:0]                    dest_base;
    logic                                     rd_en;
    logic [API_ADDR_W-1:0]                    rd_addr;
    logic [1:0][API_HALF_W-1:0]               rd_data;
    mem_cmd_t                                 wr_cmd;
    logic [API_ADDR_W-1:0]                    wr_addr;
    logic [COEFF_PER_CLK-1:0][MEM_LANE_W-1:0] wr_data;
    logic                                     done;
    logic [WORD_W-1:0]                        api_mem [IMG_DEPTH];
    int                                       seed;
    int                                       err_cnt;
    int                                       done_cnt;
    int                                       timeouts;
    int                                       exp_done;
    int                                       chk_errs;

    always #4 clk = ~clk;

    // API memory with one cycle of read latency and half 0 in the low bits
    always @(posedge clk) begin
        if (rd_en) begin
            rd_data <= api_mem[rd_addr[$clog2(IMG_DEPTH)-1:0]];
        end
    end

    dcmp_top dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize),
        .start_i     (start),
        .mode_i      (mode),
        .num_poly_i  (num_poly),
        .src_base_i  (src_base),
        .dest_base_i (dest_base),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data),
        .wr_cmd_o    (wr_cmd),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .done_o      (done)
    );

    dcmp_monitor #(.IMG_DEPTH(IMG_DEPTH)) u_monitor (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize),
        .start_i     (start),
        .mode_i      (mode),
        .num_poly_i  (num_poly),
        .src_base_i  (src_base),
        .dest_base_i (dest_base),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .wr_cmd_i    (wr_cmd),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .done_i      (done),
        .img_i       (api_mem),
        .err_cnt_o   (err_cnt),
        .done_cnt_o  (done_cnt)
    );

    task automatic issue_cmd(input dcmp_mode_t m, input int np, input int src, input int dst);
        @(negedge clk);
        mode      = m;
        num_poly  = 3'(np);
        src_base  = API_ADDR_W'(src);
        dest_base = API_ADDR_W'(dst);
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Each wait stands for one command that has to complete
    task automatic wait_done();
        int n;
        n = 0;
        exp_done++;
        while (!done && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("timeout: done_o did not arrive within %0d cycles", DONE_LIMIT);
            timeouts++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        zeroize   = 1'b0;
        start     = 1'b0;
        mode      = mode_d1;
        num_poly  = 3'd1;
        src_base  = '0;
        dest_base = '0;
        rd_data   = '0;
        timeouts  = 0;
        exp_done  = 0;
        chk_errs  = 0;
        seed      = 32'h02ec_63b1;
        for (int i = 0; i < IMG_DEPTH; i++) begin
            api_mem[i] = {$random(seed), $random(seed)};
        end
        idle_cycles(8);
        reset_n = 1'b1;
        idle_cycles(2);

        // One command per mode, covering 1 to 4 polynomials
        issue_cmd(mode_d1, 1, 3, 16);
        wait_done();
        issue_cmd(mode_d5, 2, 40, 300);
        wait_done();
        issue_cmd(mode_d11, 3, 7, 1000);
        wait_done();
        issue_cmd(mode_d12, 4, 200, 16380);
        wait_done();

        // A second start mid-command must not disturb the first
        issue_cmd(mode_d11, 2, 100, 64);
        idle_cycles(20);
        src_base  = API_ADDR_W'(5);
        dest_base = API_ADDR_W'(9);
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done();

        // Zeroize mid-command, then check nothing moves and a new command works
        issue_cmd(mode_d5, 3, 60, 500);
        idle_cycles(40);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        idle_cycles(100);
        issue_cmd(mode_d12, 1, 11, 700);
        wait_done();
        idle_cycles(10);

        if (done_cnt != exp_done) begin
            $display("[FAIL] done_count expected %0d actual %0d", exp_done, done_cnt);
            chk_errs++;
        end
        $display("errors: %0d, timeouts: %0d, commands done: %0d",
                 err_cnt + chk_errs, timeouts, done_cnt);
        if (err_cnt == 0 && chk_errs == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/dcmp_params_pkg.sv
source/dcmp_types_pkg.sv
source/dcmp_read_ctrl.sv
source/dcmp_unpack.sv
source/dcmp_write_ctrl.sv
source/dcmp_top.sv
dv/dcmp_unpack_chk.sv
dv/dcmp_monitor.sv
dv/dcmp_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= dcmp_tb
RTL_TOP    ?= dcmp_top
FILELIST   ?= tb.f
RTL_FILES  := source/dcmp_params_pkg.sv source/dcmp_types_pkg.sv \
              source/dcmp_read_ctrl.sv source/dcmp_unpack.sv \
              source/dcmp_write_ctrl.sv source/dcmp_top.sv
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
